// File: hdl/exec_pkg.sv
package exec_pkg;

	// datapath widths
	localparam int xlen      = 32; // operand and result width
	localparam int tag_width = 4;  // destination tag carried with each op

	// pipeline and queue sizing
	localparam int mult_stages     = 4; // multiplier latency in cycles
	localparam int merge_depth     = 4; // alu result queue entries
	localparam int merge_ptr_width = $clog2(merge_depth);
	localparam int merge_cnt_width = $clog2(merge_depth + 1); // holds 0..merge_depth

	// alu and branch-condition function codes
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_slt  = 4'd5,  // signed compare
		alu_sltu = 4'd6,  // unsigned compare
		alu_sll  = 4'd7,
		alu_srl  = 4'd8,
		alu_sra  = 4'd9,
		br_beq   = 4'd10, // branches write 0 and set taken
		br_bne   = 4'd11,
		br_blt   = 4'd12,
		br_bge   = 4'd13,
		br_bltu  = 4'd14,
		br_bgeu  = 4'd15
	} alu_func_t;

	// M-extension multiply forms
	typedef enum logic [1:0] {
		mul_lo   = 2'd0, // low word
		mul_hi   = 2'd1, // signed x signed, high word
		mul_hisu = 2'd2, // signed x unsigned, high word
		mul_hiu  = 2'd3  // unsigned x unsigned, high word
	} mul_func_t;

endpackage

// File: hdl/pipe_delay.sv
`timescale 1ns/1ns
module pipe_delay #(
	parameter type payload_t = logic,
	parameter int  depth     = 2
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);
	logic     valid_q [depth]; // one valid bit per stage
	payload_t data_q  [depth]; // payload, not reset

	// valid chain, killed by reset or flush
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			for (int i = 0; i < depth; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			valid_q[0] <= in_valid;
			for (int i = 1; i < depth; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		data_q[0] <= in_data;
		for (int i = 1; i < depth; i++) begin
			data_q[i] <= data_q[i-1]; // plain shift
		end
	end

	assign out_valid = valid_q[depth-1];
	assign out_data  = data_q[depth-1];

	// no x on the valid output once out of reset
	a_out_valid_known: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(out_valid));

endmodule

// File: hdl/alu_unit.sv
`timescale 1ns/1ns
module alu_unit import exec_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  logic                 alu_valid,
	input  alu_func_t            alu_func,
	input  logic [xlen-1:0]      alu_a,
	input  logic [xlen-1:0]      alu_b,
	input  logic [tag_width-1:0] alu_tag,
	output logic                 alu_done,
	output logic [tag_width-1:0] alu_done_tag,
	output logic [xlen-1:0]      alu_done_result,
	output logic                 alu_done_taken
);
	logic signed [xlen-1:0] a_s;    // signed views for slt, sra, blt, bge
	logic signed [xlen-1:0] b_s;
	logic        [4:0]      shamt;  // shift amount from b
	logic        [xlen-1:0] result; // comb result
	logic                   taken;  // comb branch condition
	logic                   is_br;

	assign a_s   = alu_a;
	assign b_s   = alu_b;
	assign shamt = alu_b[4:0];
	assign is_br = alu_func inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};

	always_comb begin
		result = '0; // branches leave result at zero
		taken  = 1'b0;
		case (alu_func)
			alu_add:  result = alu_a + alu_b;
			alu_sub:  result = alu_a - alu_b;
			alu_and:  result = alu_a & alu_b;
			alu_or:   result = alu_a | alu_b;
			alu_xor:  result = alu_a ^ alu_b;
			alu_slt:  result = {{(xlen-1){1'b0}}, a_s < b_s};
			alu_sltu: result = {{(xlen-1){1'b0}}, alu_a < alu_b};
			alu_sll:  result = alu_a << shamt;
			alu_srl:  result = alu_a >> shamt;
			alu_sra:  result = a_s >>> shamt; // sign fill
			br_beq:   taken  = (alu_a == alu_b);
			br_bne:   taken  = (alu_a != alu_b);
			br_blt:   taken  = (a_s < b_s);
			br_bge:   taken  = (a_s >= b_s);
			br_bltu:  taken  = (alu_a < alu_b);
			br_bgeu:  taken  = (alu_a >= alu_b);
			default:  result = xlen'(32'hfacebeec); // x func code, keeps it latch free
		endcase
	end

	// completion valid, one cycle after issue
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			alu_done <= 1'b0; // drop op issued in the flush cycle too
		end else begin
			alu_done <= alu_valid;
		end
	end

	// payload regs
	always_ff @(posedge clock) begin
		alu_done_tag    <= alu_tag;
		alu_done_result <= result;
		alu_done_taken  <= taken;
	end

	// taken only ever comes from a branch issued the cycle before
	a_taken_branch_only: assert property (@(posedge clock) disable iff (reset)
		alu_done && alu_done_taken |-> $past(is_br));

endmodule

// File: hdl/mult_unit.sv
`timescale 1ns/1ns
module mult_unit import exec_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  logic                 mul_valid,
	input  mul_func_t            mul_func,
	input  logic [xlen-1:0]      mul_a,
	input  logic [xlen-1:0]      mul_b,
	input  logic [tag_width-1:0] mul_tag,
	output logic                 mul_done,
	output logic [tag_width-1:0] mul_done_tag,
	output logic [xlen-1:0]      mul_done_result
);
	logic                     a_signed;  // treat a as signed
	logic                     b_signed;
	logic signed [xlen:0]     a_ext;     // 33 bit operands
	logic signed [xlen:0]     b_ext;
	logic signed [2*xlen+1:0] full_prod; // 66 bit, top two bits unused
	logic        [2*xlen-1:0] prod_q [mult_stages];
	logic                     tag_valid;
	mul_func_t                func_out;  // function at last stage

	always_comb begin
		case (mul_func)
			mul_lo:   {a_signed, b_signed} = 2'b11; // low word same either way
			mul_hi:   {a_signed, b_signed} = 2'b11;
			mul_hisu: {a_signed, b_signed} = 2'b10;
			mul_hiu:  {a_signed, b_signed} = 2'b00;
			default:  {a_signed, b_signed} = 2'b11;
		endcase
	end

	assign a_ext     = {a_signed & mul_a[xlen-1], mul_a};
	assign b_ext     = {b_signed & mul_b[xlen-1], mul_b};
	assign full_prod = a_ext * b_ext;

	// product in stage 0, then carried down
	always_ff @(posedge clock) begin
		prod_q[0] <= full_prod[2*xlen-1:0];
		for (int i = 1; i < mult_stages; i++) begin
			prod_q[i] <= prod_q[i-1];
		end
	end

	// control pipe, tag plus valid
	pipe_delay #(.payload_t(logic [tag_width-1:0]), .depth(mult_stages)) i_tag_pipe (
		.clock    (clock),
		.reset    (reset),
		.flush    (flush),
		.in_valid (mul_valid),
		.in_data  (mul_tag),
		.out_valid(tag_valid),
		.out_data (mul_done_tag)
	);

	// function pipe for the final word select
	pipe_delay #(.payload_t(mul_func_t), .depth(mult_stages)) i_func_pipe (
		.clock    (clock),
		.reset    (reset),
		.flush    (flush),
		.in_valid (mul_valid),
		.in_data  (mul_func),
		.out_valid(),
		.out_data (func_out)
	);

	assign mul_done        = tag_valid;
	assign mul_done_result = (func_out == mul_lo) ? prod_q[mult_stages-1][xlen-1:0]
	                                              : prod_q[mult_stages-1][2*xlen-1:xlen];

endmodule

// File: hdl/result_merge.sv
`timescale 1ns/1ns
module result_merge import exec_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  logic                 alu_done,
	input  logic [tag_width-1:0] alu_done_tag,
	input  logic [xlen-1:0]      alu_done_result,
	input  logic                 alu_done_taken,
	input  logic                 mul_done,
	input  logic [tag_width-1:0] mul_done_tag,
	input  logic [xlen-1:0]      mul_done_result,
	output logic                 alu_ready,
	output logic                 wb_valid,
	output logic [tag_width-1:0] wb_tag,
	output logic [xlen-1:0]      wb_result,
	output logic                 wb_taken
);
	logic [tag_width-1:0]       q_tag    [merge_depth]; // alu result queue
	logic [xlen-1:0]            q_result [merge_depth];
	logic                       q_taken  [merge_depth];
	logic [merge_ptr_width-1:0] rd_ptr;  // oldest entry
	logic [merge_ptr_width-1:0] wr_ptr;  // next free slot
	logic [merge_cnt_width-1:0] count;   // occupied entries
	logic                       q_empty;
	logic                       push;
	logic                       pop;

	assign q_empty = (count == '0);
	assign pop     = !mul_done && !q_empty;            // head leaves when mul is idle
	assign push    = alu_done && (mul_done || !q_empty); // alu loses or must wait its turn

	// room for the result in the alu reg plus one new issue
	assign alu_ready = (count <= merge_cnt_width'(merge_depth - 2));

	// queue pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0; // flush empties the queue
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (pop)  rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			q_tag[wr_ptr]    <= alu_done_tag;
			q_result[wr_ptr] <= alu_done_result;
			q_taken[wr_ptr]  <= alu_done_taken;
		end
	end

	// writeback valid
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= mul_done || !q_empty || alu_done;
		end
	end

	// writeback payload, mul first, then queue head, then alu bypass
	always_ff @(posedge clock) begin
		if (mul_done) begin
			wb_tag    <= mul_done_tag;
			wb_result <= mul_done_result;
			wb_taken  <= 1'b0; // mul never takes
		end else if (!q_empty) begin
			wb_tag    <= q_tag[rd_ptr];
			wb_result <= q_result[rd_ptr];
			wb_taken  <= q_taken[rd_ptr];
		end else begin
			wb_tag    <= alu_done_tag;
			wb_result <= alu_done_result;
			wb_taken  <= alu_done_taken;
		end
	end

	// alu issue discipline upstream keeps the queue from overflowing
	a_no_overflow: assert property (@(posedge clock) disable iff (reset || flush)
		push && !pop |-> count < merge_depth);

	// a mul completion shows up next cycle with taken clear
	a_mul_not_taken: assert property (@(posedge clock) disable iff (reset)
		mul_done && !flush |=> wb_valid && !wb_taken);

endmodule

// File: hdl/exec_stage.sv
`timescale 1ns/1ns
module exec_stage import exec_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	// alu issue
	input  logic                 alu_valid,
	input  alu_func_t            alu_func,
	input  logic [xlen-1:0]      alu_a,
	input  logic [xlen-1:0]      alu_b,
	input  logic [tag_width-1:0] alu_tag,
	output logic                 alu_ready,
	// mul issue, no back-pressure
	input  logic                 mul_valid,
	input  mul_func_t            mul_func,
	input  logic [xlen-1:0]      mul_a,
	input  logic [xlen-1:0]      mul_b,
	input  logic [tag_width-1:0] mul_tag,
	// writeback
	output logic                 wb_valid,
	output logic [tag_width-1:0] wb_tag,
	output logic [xlen-1:0]      wb_result,
	output logic                 wb_taken
);
	logic                 alu_done;        // alu completion
	logic [tag_width-1:0] alu_done_tag;
	logic [xlen-1:0]      alu_done_result;
	logic                 alu_done_taken;
	logic                 mul_done;        // mul completion
	logic [tag_width-1:0] mul_done_tag;
	logic [xlen-1:0]      mul_done_result;

	alu_unit i_alu (
		.clock, .reset, .flush,
		.alu_valid, .alu_func, .alu_a, .alu_b, .alu_tag,
		.alu_done, .alu_done_tag, .alu_done_result, .alu_done_taken
	);

	mult_unit i_mult (
		.clock, .reset, .flush,
		.mul_valid, .mul_func, .mul_a, .mul_b, .mul_tag,
		.mul_done, .mul_done_tag, .mul_done_result
	);

	result_merge i_merge (
		.clock, .reset, .flush,
		.alu_done, .alu_done_tag, .alu_done_result, .alu_done_taken,
		.mul_done, .mul_done_tag, .mul_done_result,
		.alu_ready, .wb_valid, .wb_tag, .wb_result, .wb_taken
	);

endmodule

// File: tests/exec_stage_tb.sv
`timescale 1ns/1ns
module exec_stage_tb import exec_pkg::*; ;

	localparam int alu_cycles   = 850; // alu_random issue cycles, about 400 ops
	localparam int mul_cycles   = 220;
	localparam int mix_cycles   = 300;
	localparam int bp_cycles    = 60;
	localparam int flush_cycles = 42;  // includes the two flush cycles
	localparam int cycle_limit  =
		4 * (alu_cycles + mul_cycles + mix_cycles + bp_cycles + flush_cycles) + 200;

	logic                 clock = 1'b0;
	logic                 reset;
	logic                 flush;
	logic                 alu_valid;
	alu_func_t            alu_func;
	logic [xlen-1:0]      alu_a;
	logic [xlen-1:0]      alu_b;
	logic [tag_width-1:0] alu_tag;
	logic                 alu_ready;
	logic                 mul_valid;
	mul_func_t            mul_func;
	logic [xlen-1:0]      mul_a;
	logic [xlen-1:0]      mul_b;
	logic [tag_width-1:0] mul_tag;
	logic                 wb_valid;
	logic [tag_width-1:0] wb_tag;
	logic [xlen-1:0]      wb_result;
	logic                 wb_taken;

	// reference model, indexed by tag
	bit          pending    [16];
	bit          flushed    [16]; // issued around a flush, must never write back
	bit          tag_is_mul [16];
	logic [31:0] exp_result [16];
	bit          exp_taken  [16];
	int          issue_cyc  [16]; // negedge count at drive time
	int          alu_order  [$];  // alu tags in issue order

	logic [31:0] rng_state = 32'd81;
	int          cycle = 0;
	int          value_errors = 0;
	int          protocol_errors = 0;
	int          next_tag = 0;
	bit          ready_s = 1'b1;  // alu_ready as seen at the last negedge
	bit          alu_prev1 = 1'b0; // alu_valid driven one cycle back
	bit          alu_prev2 = 1'b0; // and two cycles back
	bit          saw_not_ready = 1'b0;
	string       test_name = "reset";

	exec_stage i_dut (.*);

	always #2 clock = ~clock;

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// zero, all ones and signed min show up often
	function automatic logic [31:0] rand_operand();
		logic [31:0] r;
		r = xorshift32();
		case (r[2:0])
			3'd0: return 32'h0000_0000;
			3'd1: return 32'hffff_ffff;
			3'd2: return 32'h8000_0000;
			default: return xorshift32();
		endcase
	endfunction

	// returns {taken, result}
	function automatic logic [32:0] alu_model(input logic [3:0] f, input logic [31:0] a,
			input logic [31:0] b);
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		sa = a;
		sb = b;
		case (f)
			4'd0:  return {1'b0, a + b};
			4'd1:  return {1'b0, a - b};
			4'd2:  return {1'b0, a & b};
			4'd3:  return {1'b0, a | b};
			4'd4:  return {1'b0, a ^ b};
			4'd5:  return {1'b0, 31'd0, sa < sb};
			4'd6:  return {1'b0, 31'd0, a < b};
			4'd7:  return {1'b0, a << b[4:0]};
			4'd8:  return {1'b0, a >> b[4:0]};
			4'd9:  return {1'b0, 32'(sa >>> b[4:0])};
			4'd10: return {a == b, 32'd0};
			4'd11: return {a != b, 32'd0};
			4'd12: return {sa < sb, 32'd0};
			4'd13: return {sa >= sb, 32'd0};
			4'd14: return {a < b, 32'd0};
			default: return {a >= b, 32'd0};
		endcase
	endfunction

	function automatic logic [31:0] mul_model(input logic [1:0] f, input logic [31:0] a,
			input logic [31:0] b);
		logic [63:0] ea;
		logic [63:0] eb;
		logic [63:0] p;
		ea = (f != 2'd3) ? {{32{a[31]}}, a} : {32'd0, a}; // a signed except mulhu
		eb = (f <= 2'd1) ? {{32{b[31]}}, b} : {32'd0, b};
		p  = ea * eb; // mod 2^64 is exact for 33x33 bit operands
		return (f == 2'd0) ? p[31:0] : p[63:32];
	endfunction

	// round robin over free tags, -1 if none
	function automatic int alloc_tag();
		int t;
		for (int i = 0; i < 16; i++) begin
			t = (next_tag + i) % 16;
			if (!pending[t] && !flushed[t]) begin
				next_tag = (t + 1) % 16;
				return t;
			end
		end
		return -1;
	endfunction

	function automatic bit any_pending();
		for (int t = 0; t < 16; t++) begin
			if (pending[t]) return 1'b1;
		end
		return 1'b0;
	endfunction

	// called right after a rising edge
	task automatic issue_alu(input bit want);
		int          t;
		logic [3:0]  f;
		logic [31:0] a;
		logic [31:0] b;
		logic [32:0] m;
		// an alu op from two cycles back may take a queue slot at this edge and drop ready
		t = want && ready_s && !alu_prev2 ? alloc_tag() : -1;
		if (t < 0) begin
			alu_valid <= 1'b0;
		end else begin
			f = xorshift32() % 16;
			a = rand_operand();
			b = rand_operand();
			m = alu_model(f, a, b);
			pending[t]    = 1'b1;
			tag_is_mul[t] = 1'b0;
			exp_result[t] = m[31:0];
			exp_taken[t]  = m[32];
			alu_order.push_back(t);
			alu_valid <= 1'b1;
			alu_func  <= alu_func_t'(f);
			alu_a     <= a;
			alu_b     <= b;
			alu_tag   <= t;
		end
	endtask

	task automatic issue_mul(input bit want);
		int          t;
		logic [1:0]  f;
		logic [31:0] a;
		logic [31:0] b;
		t = want ? alloc_tag() : -1;
		if (t < 0) begin
			mul_valid <= 1'b0;
		end else begin
			f = xorshift32() % 4;
			a = rand_operand();
			b = rand_operand();
			pending[t]    = 1'b1;
			tag_is_mul[t] = 1'b1;
			exp_result[t] = mul_model(f, a, b);
			exp_taken[t]  = 1'b0;
			issue_cyc[t]  = cycle;
			mul_valid <= 1'b1;
			mul_func  <= mul_func_t'(f);
			mul_a     <= a;
			mul_b     <= b;
			mul_tag   <= t;
		end
	endtask

	// stop issuing and wait for every tag to come back
	task automatic drain();
		int waited;
		waited = 0;
		@(posedge clock);
		alu_valid <= 1'b0;
		mul_valid <= 1'b0;
		while (any_pending() && waited < 100) begin
			@(posedge clock);
			waited++;
		end
		for (int t = 0; t < 16; t++) begin
			if (pending[t]) begin
				$display("%s: tag %0d was issued but never written back", test_name, t);
				protocol_errors++;
				pending[t] = 1'b0;
			end
		end
		alu_order.delete();
	endtask

	task automatic run_phase(input string name, input int cycles, input int alu_pct,
			input int mul_pct);
		test_name = name;
		repeat (cycles) begin
			@(posedge clock);
			issue_mul(xorshift32() % 100 < mul_pct); // mul takes a tag first
			issue_alu(xorshift32() % 100 < alu_pct);
		end
		drain();
	endtask

	task automatic flush_test();
		test_name = "flush_drop";
		@(posedge clock);
		issue_mul(1'b1);
		issue_alu(1'b1);
		@(posedge clock);
		flush <= 1'b1;
		issue_mul(1'b1); // presented in the flush cycle, dropped too
		issue_alu(1'b1);
		for (int t = 0; t < 16; t++) begin
			flushed[t] = pending[t];
			pending[t] = 1'b0;
		end
		alu_order.delete();
		@(posedge clock);
		flush     <= 1'b0;
		alu_valid <= 1'b0;
		mul_valid <= 1'b0;
		@(negedge clock);
		if (alu_ready !== 1'b1) begin
			$display("%s: alu_ready not high on the cycle after the flush", test_name);
			protocol_errors++;
		end
		repeat (12) @(posedge clock); // anything leaking out would show by now
		for (int t = 0; t < 16; t++) flushed[t] = 1'b0;
		run_phase("flush_drop", flush_cycles - 2, 50, 30);
	endtask

	task automatic check_wb();
		int t;
		t = wb_tag;
		if (flushed[t]) begin
			$display("%s: writeback for tag %0d which was flushed", test_name, t);
			protocol_errors++;
		end else if (!pending[t]) begin
			$display("%s: writeback for tag %0d which is not pending", test_name, t);
			protocol_errors++;
		end else begin
			if (wb_result !== exp_result[t]) begin
				$display("[ERROR] %s: tag %0d result expected %h actual %h",
					test_name, t, exp_result[t], wb_result);
				value_errors++;
			end
			if (wb_taken !== exp_taken[t]) begin
				$display("[ERROR] %s: tag %0d taken expected %0d actual %0d",
					test_name, t, exp_taken[t], wb_taken);
				value_errors++;
			end
			if (tag_is_mul[t]) begin
				if (cycle != issue_cyc[t] + 6) begin // 5 cycles after acceptance
					$display("[ERROR] %s: tag %0d mul latency expected %0d actual %0d",
						test_name, t, 5, cycle - issue_cyc[t] - 1);
					value_errors++;
				end
			end else begin
				if (alu_order.size() == 0 || alu_order[0] != t) begin
					$display("%s: alu tag %0d written back out of issue order", test_name, t);
					protocol_errors++;
				end
				if (alu_order.size() != 0) void'(alu_order.pop_front());
			end
			pending[t] = 1'b0;
		end
	endtask

	// sample outputs mid cycle where they are stable
	always @(negedge clock) begin
		cycle++;
		ready_s   = alu_ready;
		alu_prev2 = alu_prev1;
		alu_prev1 = alu_valid;
		if (!reset && !alu_ready) saw_not_ready = 1'b1;
		if (cycle > cycle_limit) begin
			$display("timeout after %0d cycles, run stopped", cycle);
			$display("Test failures found");
			$finish;
		end
		if (!reset && wb_valid) check_wb();
	end

	initial begin
		reset     = 1'b1;
		flush     = 1'b0;
		alu_valid = 1'b0;
		alu_func  = alu_add;
		alu_a     = '0;
		alu_b     = '0;
		alu_tag   = '0;
		mul_valid = 1'b0;
		mul_func  = mul_lo;
		mul_a     = '0;
		mul_b     = '0;
		mul_tag   = '0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;

		run_phase("alu_random", alu_cycles, 90, 0);
		run_phase("mul_random", mul_cycles, 0, 90);
		run_phase("merge_mix", mix_cycles, 60, 40);
		saw_not_ready = 1'b0;
		run_phase("alu_backpressure", bp_cycles, 100, 100);
		if (!saw_not_ready) begin
			$display("alu_backpressure: alu_ready never went low");
			protocol_errors++;
		end
		flush_test();

		$display("value errors %0d, protocol errors %0d", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: exec_stage.f
hdl/exec_pkg.sv
hdl/pipe_delay.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/result_merge.sv
hdl/exec_stage.sv
tests/exec_stage_tb.sv
